// ==== Bender.yml ====
package:
  name: decode_stage

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cpuPkg.sv
      - rtl/decodeIfs.sv
      - rtl/controlUnit.sv
      - rtl/registerFile.sv
      - rtl/issueStage.sv
      - rtl/decodeTop.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verification/decodeTb.sv

// ==== list.f ====
+incdir+rtl
rtl/cpuPkg.sv
rtl/decodeIfs.sv
rtl/controlUnit.sv
rtl/registerFile.sv
rtl/issueStage.sv
rtl/decodeTop.sv
verification/decodeTb.sv

// ==== rtl/controlUnit.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cpu_consts.svh"

module controlUnit import cpuPkg::*; (
  input  logic [`DATA_W-1:0] inst,  // Fetched instruction word
  decodeCtrlIf.ctrl          ctrl,  // Decoded control toward issue
  regReadIf.addr             rd     // Read addresses to the register file
);

  opcodeE             opcode;   // Upper nibble as an opcode
  logic [`REG_AW-1:0] rdField;
  logic [`REG_AW-1:0] rsField;
  logic [`REG_AW-1:0] rtField;

  assign opcode  = opcodeE'(inst[`OPC_HI:`OPC_LO]);
  assign rdField = inst[`RD_HI:`RD_LO];
  assign rsField = inst[`RS_HI:`RS_LO];
  assign rtField = inst[`NIB_HI:0];

  //////////////////////////////
  // Opcode decode
  //////////////////////////////
  always_comb begin
    // Defaults describe an instruction with no side effects
    ctrl.aluSrc    = 1'b0;
    ctrl.regSrc    = 1'b0;
    ctrl.memEnable = 1'b0;
    ctrl.memWrite  = 1'b0;
    ctrl.memToReg  = 1'b0;
    ctrl.regWrite  = 1'b0;
    ctrl.branch    = 1'b0;
    ctrl.branchReg = 1'b0;
    ctrl.halt      = 1'b0;
    ctrl.pcs       = 1'b0;
    ctrl.zEn       = 1'b0;
    ctrl.nvEn      = 1'b0;
    ctrl.aluOp     = ADD;  // Address and PC math use the adder
    unique case (opcode)
      ADD, SUB: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = opcode;
        ctrl.zEn      = 1'b1;
        ctrl.nvEn     = 1'b1;  // Only add and sub report overflow and sign
      end
      XOR: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = opcode;
        ctrl.zEn      = 1'b1;
      end
      RED, PADDSB: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = opcode;  // No flag update
      end
      SLL, SRA, ROR: begin
        ctrl.aluSrc   = 1'b1;  // Shift amount from rt slot
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = opcode;
        ctrl.zEn      = 1'b1;
      end
      LW: begin
        ctrl.aluSrc    = 1'b1;
        ctrl.memEnable = 1'b1;
        ctrl.memToReg  = 1'b1;
        ctrl.regWrite  = 1'b1;
      end
      SW: begin
        ctrl.aluSrc    = 1'b1;
        ctrl.memEnable = 1'b1;
        ctrl.memWrite  = 1'b1;
      end
      LLB, LHB: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.regSrc   = 1'b1;  // Old rd value is merged with the byte
        ctrl.regWrite = 1'b1;
      end
      B:   ctrl.branch = 1'b1;
      BR: begin
        ctrl.branch    = 1'b1;
        ctrl.branchReg = 1'b1;
      end
      PCS: begin
        ctrl.pcs      = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      HLT: ctrl.halt = 1'b1;
    endcase
  end

  // Instruction fields
  assign ctrl.rd        = rdField;
  assign ctrl.cond      = branchCondE'(inst[`RD_HI:`COND_LO]);
  assign ctrl.shortImm  = inst[`NIB_HI:0];
  assign ctrl.byteImm   = inst[`BYTE_HI:0];
  assign ctrl.branchImm = inst[`BIMM_HI:0];

  // Read port selection
  assign rd.rdAddr1 = ctrl.regSrc   ? rdField : rsField;  // rd for LLB/LHB
  assign rd.rdAddr2 = ctrl.memWrite ? rdField : rtField;  // rd holds SW store data

  // A store must also be a memory access downstream
  memWriteNeedsEnable: assert final (!ctrl.memWrite || ctrl.memEnable)
    else $error("memWrite decoded without memEnable");

endmodule

`default_nettype wire

// ==== rtl/cpuPkg.sv ====
package cpuPkg;

  ////////////////////////////////
  // Opcodes, upper nibble of the instruction word
  typedef enum logic [3:0] {
    ADD    = 4'h0,  // rd = rs + rt, saturating
    SUB    = 4'h1,  // rd = rs - rt, saturating
    XOR    = 4'h2,
    RED    = 4'h3,  // Reduction add of nibbles
    SLL    = 4'h4,  // Shift left by imm
    SRA    = 4'h5,  // Arithmetic shift right by imm
    ROR    = 4'h6,  // Rotate right by imm
    PADDSB = 4'h7,  // Parallel nibble add, saturating
    LW     = 4'h8,  // rd = mem[rs + off]
    SW     = 4'h9,  // mem[rs + off] = rd
    LLB    = 4'hA,  // Load low byte into rd
    LHB    = 4'hB,  // Load high byte into rd
    B      = 4'hC,  // PC-relative conditional branch
    BR     = 4'hD,  // Register conditional branch
    PCS    = 4'hE,  // rd = next PC
    HLT    = 4'hF   // Stop issue until reset
  } opcodeE;

  ////////////////////////////////
  // Branch conditions, tested against {Z, V, N}
  typedef enum logic [2:0] {
    NE     = 3'd0,  // Z clear
    EQ     = 3'd1,  // Z set
    GT     = 3'd2,  // Z and N clear
    LT     = 3'd3,  // N set
    GE     = 3'd4,  // Z set or N clear
    LE     = 3'd5,  // Z or N set
    OV     = 3'd6,  // V set
    UNCOND = 3'd7   // Always taken
  } branchCondE;

  // Operation handed to execute
  // Same encoding as the opcode, ADD for address and PC math
  typedef opcodeE aluOpT;

endpackage

// ==== rtl/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath sizes
`define DATA_W      16  // Data and address width
`define REG_CNT     16  // Architectural registers
`define REG_AW      4   // Register address width

// Credit flow toward execute
`define DEC_CREDITS 2   // Bundles the consumer can buffer
`define CREDIT_W    2   // Credit counter width

// Instruction field positions
`define OPC_HI      15  // Opcode nibble [15:12]
`define OPC_LO      12
`define RD_HI       11  // rd nibble [11:8]
`define RD_LO       8
`define RS_HI       7   // rs nibble [7:4]
`define RS_LO       4
`define COND_LO     9   // Branch condition [11:9]
`define BIMM_HI     8   // Branch offset [8:0]
`define BYTE_HI     7   // LLB/LHB byte [7:0]
`define NIB_HI      3   // rt, shift amount or memory offset [3:0]

`endif

// ==== rtl/decodeIfs.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cpu_consts.svh"

// Decoded control from the opcode decoder to the issue stage
interface decodeCtrlIf import cpuPkg::*; ();
  logic                aluSrc;     // Immediate as second operand
  logic                regSrc;     // rd read as first source (LLB/LHB)
  logic                memEnable;  // LW or SW
  logic                memWrite;   // SW only
  logic                memToReg;   // Write back load data
  logic                regWrite;
  logic                branch;     // B or BR
  logic                branchReg;  // Target from register (BR)
  logic                halt;
  logic                pcs;
  logic                zEn;        // Execute may update Z
  logic                nvEn;       // Execute may update N and V
  aluOpT               aluOp;
  logic [`REG_AW-1:0]  rd;         // Destination register
  branchCondE          cond;
  logic [3:0]          shortImm;   // Shift amount or memory offset
  logic [7:0]          byteImm;    // LLB/LHB payload
  logic [8:0]          branchImm;  // Word offset for B

  modport ctrl (output aluSrc, regSrc, memEnable, memWrite, memToReg, regWrite,
                       branch, branchReg, halt, pcs, zEn, nvEn,
                       aluOp, rd, cond, shortImm, byteImm, branchImm);

  modport issue (input aluSrc, regSrc, memEnable, memWrite, memToReg, regWrite,
                       branch, branchReg, halt, pcs, zEn, nvEn,
                       aluOp, rd, cond, shortImm, byteImm, branchImm);
endinterface

// Register file read path, addresses in and data out
interface regReadIf ();
  logic [`REG_AW-1:0] rdAddr1;
  logic [`REG_AW-1:0] rdAddr2;
  logic [`DATA_W-1:0] rdData1;  // Combinational, forwarded
  logic [`DATA_W-1:0] rdData2;

  modport addr (output rdAddr1, rdAddr2);                  // Decoder side
  modport port (input rdAddr1, rdAddr2,
                output rdData1, rdData2);                  // Register file side
  modport data (input rdData1, rdData2);                   // Issue side
endinterface

`default_nettype wire

// ==== rtl/decodeTop.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cpu_consts.svh"

module decodeTop (
  input  logic               clk,
  input  logic               rstN,          // Synchronous, active low
  // Fetch side
  input  logic               instValid,
  output logic               instReady,
  input  logic [`DATA_W-1:0] inst,
  input  logic [`DATA_W-1:0] pcNext,
  input  logic [2:0]         flags,         // {Z, V, N}
  // Write-back port into the register file
  input  logic [`REG_AW-1:0] wbRd,
  input  logic               wbWrite,
  input  logic [`DATA_W-1:0] wbData,
  input  logic               creditReturn,
  // Issued bundles
  output logic               outValid,
  output logic [`DATA_W-1:0] exAluIn1,
  output logic [`DATA_W-1:0] exAluIn2,
  output logic [3:0]         exAluOp,
  output logic               exZEn,
  output logic               exNvEn,
  output logic [`DATA_W-1:0] memWriteData,
  output logic               memEnable,
  output logic               memWrite,
  output logic [`REG_AW-1:0] wbDst,
  output logic               wbRegWrite,
  output logic               wbMemToReg,
  output logic               wbHalt,
  output logic               wbPcs,
  output logic [`DATA_W-1:0] branchTarget,
  output logic               branchTaken
);

  decodeCtrlIf ctrlBus ();  // Decoder to issue
  regReadIf    readBus ();  // Shared by all three blocks

  controlUnit iCU (
    .inst (inst),
    .ctrl (ctrlBus.ctrl),
    .rd   (readBus.addr)
  );

  registerFile iRF (
    .clk     (clk),
    .rstN    (rstN),
    .wbRd    (wbRd),
    .wbWrite (wbWrite),
    .wbData  (wbData),
    .rd      (readBus.port)
  );

  issueStage iIS (
    .clk, .rstN, .instValid, .instReady, .pcNext, .flags, .creditReturn,
    .ctrl (ctrlBus.issue),
    .rd   (readBus.data),
    .outValid, .exAluIn1, .exAluIn2, .exAluOp, .exZEn, .exNvEn,
    .memWriteData, .memEnable, .memWrite,
    .wbDst, .wbRegWrite, .wbMemToReg, .wbHalt, .wbPcs,
    .branchTarget, .branchTaken
  );

endmodule

`default_nettype wire

// ==== rtl/issueStage.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cpu_consts.svh"

module issueStage import cpuPkg::*; (
  input  logic               clk,
  input  logic               rstN,
  input  logic               instValid,     // Fetch offers an instruction
  output logic               instReady,     // Credits left and no halt
  input  logic [`DATA_W-1:0] pcNext,
  input  logic [2:0]         flags,         // {Z, V, N}
  input  logic               creditReturn,  // One pulse per freed bundle slot
  decodeCtrlIf.issue         ctrl,
  regReadIf.data             rd,
  output logic               outValid,      // One cycle per issued bundle
  output logic [`DATA_W-1:0] exAluIn1,
  output logic [`DATA_W-1:0] exAluIn2,
  output logic [3:0]         exAluOp,
  output logic               exZEn,
  output logic               exNvEn,
  output logic [`DATA_W-1:0] memWriteData,
  output logic               memEnable,
  output logic               memWrite,
  output logic [`REG_AW-1:0] wbDst,
  output logic               wbRegWrite,
  output logic               wbMemToReg,
  output logic               wbHalt,
  output logic               wbPcs,
  output logic [`DATA_W-1:0] branchTarget,
  output logic               branchTaken
);

  logic                 zFlag, vFlag, nFlag;
  logic [`DATA_W-1:0]   aluIn2;
  logic                 condMet;
  logic                 taken;
  logic [`DATA_W-1:0]   target;
  logic                 accept;      // Handshake on this edge
  logic [`CREDIT_W-1:0] credits;     // Free slots at the consumer
  logic                 haltLock;    // Set by an issued HLT

  assign {zFlag, vFlag, nFlag} = flags;

  //////////////////////////////
  // Operands
  //////////////////////////////
  always_comb begin
    if (ctrl.memEnable) begin
      aluIn2 = {{(`DATA_W-4){ctrl.shortImm[3]}}, ctrl.shortImm};  // Signed word offset
    end else if (ctrl.aluSrc && ctrl.regSrc) begin
      aluIn2 = {{(`DATA_W-8){1'b0}}, ctrl.byteImm};               // LLB/LHB byte
    end else if (ctrl.aluSrc) begin
      aluIn2 = {{(`DATA_W-4){1'b0}}, ctrl.shortImm};              // Shift amount
    end else begin
      aluIn2 = rd.rdData2;
    end
  end

  //////////////////////////////
  // Branch resolution
  //////////////////////////////
  always_comb begin
    unique case (ctrl.cond)
      NE:     condMet = !zFlag;
      EQ:     condMet = zFlag;
      GT:     condMet = !zFlag && !nFlag;
      LT:     condMet = nFlag;
      GE:     condMet = zFlag || !nFlag;
      LE:     condMet = zFlag || nFlag;
      OV:     condMet = vFlag;
      UNCOND: condMet = 1'b1;
    endcase
  end

  assign taken  = ctrl.branch && condMet;
  assign target = !taken        ? pcNext :
                  ctrl.branchReg ? rd.rdData1 :  // BR jumps to rs
                  pcNext + {{(`DATA_W-10){ctrl.branchImm[8]}}, ctrl.branchImm, 1'b0};

  //////////////////////////////
  // Credits and halt lock
  //////////////////////////////
  assign instReady = (credits != '0) && !haltLock;
  assign accept    = instValid && instReady;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      credits  <= `CREDIT_W'(`DEC_CREDITS);
      haltLock <= 1'b0;
    end else begin
      case ({accept, creditReturn})
        2'b10:   credits <= credits - 1'b1;  // Spent on issue
        2'b01:   credits <= credits + 1'b1;  // Returned by consumer
        default: credits <= credits;         // Both or neither cancel out
      endcase
      if (accept && ctrl.halt) haltLock <= 1'b1;  // Held until reset
    end
  end

  // Control bits of the bundles
  always_ff @(posedge clk) begin
    if (!rstN) begin
      outValid    <= 1'b0;
      branchTaken <= 1'b0;
      exZEn       <= 1'b0;
      exNvEn      <= 1'b0;
      memEnable   <= 1'b0;
      memWrite    <= 1'b0;
      wbRegWrite  <= 1'b0;
      wbMemToReg  <= 1'b0;
      wbHalt      <= 1'b0;
      wbPcs       <= 1'b0;
    end else begin
      outValid <= accept;
      if (accept) begin
        branchTaken <= taken;
        exZEn       <= ctrl.zEn;
        exNvEn      <= ctrl.nvEn;
        memEnable   <= ctrl.memEnable;
        memWrite    <= ctrl.memWrite;
        wbRegWrite  <= ctrl.regWrite;
        wbMemToReg  <= ctrl.memToReg;
        wbHalt      <= ctrl.halt;
        wbPcs       <= ctrl.pcs;
      end
    end
  end

  // Payload, qualified by outValid
  always_ff @(posedge clk) begin
    if (accept) begin
      exAluIn1     <= rd.rdData1;
      exAluIn2     <= aluIn2;
      exAluOp      <= ctrl.aluOp;
      memWriteData <= rd.rdData2;  // Store data read from rd
      wbDst        <= ctrl.rd;
      branchTarget <= target;
    end
  end

  creditsBounded: assert property (@(posedge clk) disable iff (!rstN)
    credits <= `CREDIT_W'(`DEC_CREDITS))
    else $error("credit counter above the consumer depth");

  // Every issued bundle consumed a credit on the previous edge
  issueSpendsCredit: assert property (@(posedge clk) disable iff (!rstN)
    outValid |-> ($past(credits) != '0) && ((credits < $past(credits)) || $past(creditReturn)))
    else $error("bundle issued without a spent credit");

endmodule

`default_nettype wire

// ==== rtl/registerFile.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cpu_consts.svh"

module registerFile (
  input  logic               clk,
  input  logic               rstN,     // Synchronous, active low
  input  logic [`REG_AW-1:0] wbRd,     // Write-back destination
  input  logic               wbWrite,  // Write-back enable
  input  logic [`DATA_W-1:0] wbData,
  regReadIf.port             rd        // Two combinational read ports
);

  logic [`DATA_W-1:0] regs [`REG_CNT];  // Register array, entry 0 unused

  //////////////////////////////
  // Write port
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      regs <= '{default: '0};
    end else if (wbWrite && (wbRd != '0)) begin  // R0 is hardwired
      regs[wbRd] <= wbData;
    end
  end

  //////////////////////////////
  // Read ports with forwarding
  //////////////////////////////
  // Same-cycle write wins over the stored value
  function automatic logic [`DATA_W-1:0] readPort(input logic [`REG_AW-1:0] addr);
    logic [`DATA_W-1:0] value;
    if (addr == '0) begin
      value = '0;                        // R0 reads zero, even while written
    end else if (wbWrite && (wbRd == addr)) begin
      value = wbData;                    // Bypass
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  // Array contents and the write port also steer the read data
  always_comb begin
    rd.rdData1 = readPort(rd.rdAddr1);
    rd.rdData2 = readPort(rd.rdAddr2);
  end

  // R0 never takes a write, whatever write-back presents
  r0StaysZero: assert property (@(posedge clk) disable iff (!rstN)
    regs[0] == '0)
    else $error("register 0 is nonzero");

endmodule

`default_nettype wire

// ==== verification/decodeCases.txt ====
# W reg value | I inst pc flags exp | F reg value inst pc flags exp | H | P inst pc flags exp | X n
# exp: aluIn1 aluIn2 aluOp zEn nvEn memWData memEn memWr wbDst regWr memToReg halt pcs target taken
W 1 0005
W 2 0003
W 3 fff0
W 4 1234
W 5 8000
W 6 0040
W 7 00ff
# arithmetic and shifts
I 0812 0010 0 0005 0003 0 1 1 0003 0 0 8 1 0 0 0 0010 0
I 1934 0012 0 fff0 1234 1 1 1 1234 0 0 9 1 0 0 0 0012 0
I 2a47 0014 0 1234 00ff 2 1 0 00ff 0 0 a 1 0 0 0 0014 0
I 3b14 0016 0 0005 1234 3 0 0 1234 0 0 b 1 0 0 0 0016 0
I 4c45 0018 0 1234 0005 4 1 0 8000 0 0 c 1 0 0 0 0018 0
I 5d5f 001a 0 8000 000f 5 1 0 0000 0 0 d 1 0 0 0 001a 0
I 6e38 001c 0 fff0 0008 6 1 0 0000 0 0 e 1 0 0 0 001c 0
I 7f13 001e 0 0005 fff0 7 0 0 fff0 0 0 f 1 0 0 0 001e 0
# loads, stores, byte loads
I 886e 0020 0 0040 fffe 0 0 0 0000 1 0 8 1 1 0 0 0020 0
I 8917 0022 0 0005 0007 0 0 0 00ff 1 0 9 1 1 0 0 0022 0
I 9463 0024 0 0040 0003 0 0 0 1234 1 1 4 0 0 0 0 0024 0
I 9728 0026 0 0003 fff8 0 0 0 00ff 1 1 7 0 0 0 0 0026 0
I a4ab 0028 0 1234 00ab 0 0 0 0000 0 0 4 1 0 0 0 0028 0
I b79c 002a 0 00ff 009c 0 0 0 0000 0 0 7 1 0 0 0 002a 0
# branches, one per condition, then BR
I c004 0100 0 0000 1234 0 0 0 1234 0 0 0 0 0 0 0 0108 1
I c004 0100 4 0000 1234 0 0 0 1234 0 0 0 0 0 0 0 0100 0
I c3f0 0200 4 0000 0000 0 0 0 0000 0 0 3 0 0 0 0 01e0 1
I c410 0300 1 0005 0000 0 0 0 0000 0 0 4 0 0 0 0 0300 0
I c623 0300 1 0003 fff0 0 0 0 fff0 0 0 6 0 0 0 0 0346 1
I c801 0400 1 0000 0005 0 0 0 0005 0 0 8 0 0 0 0 0400 0
I cbff 0400 4 0000 0000 0 0 0 0000 0 0 b 0 0 0 0 03fe 1
I cc20 0500 2 0003 0000 0 0 0 0000 0 0 c 0 0 0 0 0540 1
I cc20 0500 5 0003 0000 0 0 0 0000 0 0 c 0 0 0 0 0500 0
I cf00 0800 0 0000 0000 0 0 0 0000 0 0 f 0 0 0 0 0600 1
I d260 0900 4 0040 0000 0 0 0 0000 0 0 2 0 0 0 0 0040 1
I d060 0900 4 0040 0000 0 0 0 0000 0 0 0 0 0 0 0 0900 0
# forwarding and register 0
F 5 7777 0851 0030 0 7777 0005 0 1 1 0005 0 0 8 1 0 0 0 0030 0
F 2 beef 1912 0032 0 0005 beef 1 1 1 beef 0 0 9 1 0 0 0 0032 0
W 0 abcd
I 0800 0034 0 0000 0000 0 1 1 0000 0 0 8 1 0 0 0 0034 0
F 0 5555 2a05 0036 0 0000 7777 2 1 0 7777 0 0 a 1 0 0 0 0036 0
# back-pressure with credit returns withheld
H
I 0812 0040 0 0005 beef 0 1 1 beef 0 0 8 1 0 0 0 0040 0
I 1a51 0042 0 7777 0005 1 1 1 0005 0 0 a 1 0 0 0 0042 0
P 2b12 0044 0 0005 beef 2 1 0 beef 0 0 b 1 0 0 0 0044 0
# PCS, HLT, lock until reset, then a clean register file
I e300 0050 0 0000 0000 0 0 0 0000 0 0 3 1 0 0 1 0050 0
I f000 0052 0 0000 0000 0 0 0 0000 0 0 0 0 0 1 0 0052 0
X 8
I 0812 0060 0 0000 0000 0 1 1 0000 0 0 8 1 0 0 0 0060 0

// ==== verification/decodeTb.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"

module decodeTb;

  localparam int TIMEOUT      = 40;  // Cycles allowed for any single wait
  localparam int STALL_CYCLES = 5;   // Cycles an instruction sits under back-pressure

  logic               clk;
  logic               rstN;
  logic               instValid;
  logic               instReady;
  logic [`DATA_W-1:0] inst;
  logic [`DATA_W-1:0] pcNext;
  logic [2:0]         flags;         // {Z, V, N}
  logic [`REG_AW-1:0] wbRd;
  logic               wbWrite;
  logic [`DATA_W-1:0] wbData;
  logic               creditReturn;
  logic               outValid;
  logic [`DATA_W-1:0] exAluIn1;
  logic [`DATA_W-1:0] exAluIn2;
  logic [3:0]         exAluOp;
  logic               exZEn;
  logic               exNvEn;
  logic [`DATA_W-1:0] memWriteData;
  logic               memEnable;
  logic               memWrite;
  logic [`REG_AW-1:0] wbDst;
  logic               wbRegWrite;
  logic               wbMemToReg;
  logic               wbHalt;
  logic               wbPcs;
  logic [`DATA_W-1:0] branchTarget;
  logic               branchTaken;

  // Consumer model
  int                 dueQ[$];       // Cycle at which each credit goes back
  int                 outstanding;   // Bundles seen but not yet returned
  int                 cycleCount;
  logic               holdReturns;   // Withhold credits for back-pressure
  logic               resetting;
  logic [31:0]        lfsrState;

  logic [`DATA_W-1:0] expV [15];     // Expected bundle of the current case
  int                 caseNum;

  decodeTop DUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////
  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic stopWithError(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [`DATA_W-1:0] expected,
                            input logic [`DATA_W-1:0] actual);
    assert (actual === expected)
      else stopWithError($sformatf("[ERROR] %s expected %h actual %h (case %0d)",
                                   name, expected, actual, caseNum));
  endtask

  task automatic applyReset();
    resetting = 1'b1;
    rstN      = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    dueQ.delete();          // Consumer buffers empty again
    outstanding  = 0;
    creditReturn = 1'b0;
    holdReturns  = 1'b0;
    rstN         = 1'b1;
    resetting    = 1'b0;
    checkValue("outValid", '0, outValid);
    checkValue("branchTaken", '0, branchTaken);
    checkValue("memEnable", '0, memEnable);
    checkValue("memWrite", '0, memWrite);
    checkValue("wbRegWrite", '0, wbRegWrite);
    checkValue("wbHalt", '0, wbHalt);
    checkValue("instReady", 16'h1, instReady);  // Full credits after reset
  endtask

  // One write-back cycle with no instruction
  task automatic driveWrite(input logic [`REG_AW-1:0] r, input logic [`DATA_W-1:0] v);
    wbRd    = r;
    wbData  = v;
    wbWrite = 1'b1;
    @(posedge clk);
    #1;
    wbWrite = 1'b0;
  endtask

  task automatic waitReady();
    int waited;
    waited = 0;
    while (!instReady && waited < TIMEOUT) begin
      checkValue("outValid", '0, outValid);  // Nothing issues while stalled
      @(posedge clk);
      #1;
      waited++;
    end
    if (!instReady)
      stopWithError($sformatf("instReady did not rise within %0d cycles in case %0d",
                              TIMEOUT, caseNum));
  endtask

  task automatic waitOutValid();
    int waited;
    waited = 0;
    while (!outValid && waited < TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!outValid)
      stopWithError($sformatf("no bundle issued in case %0d", caseNum));
    checkValue("outValid latency", '0, 16'(waited));  // One cycle decode
  endtask

  task automatic issueAndCheck();
    waitReady();
    @(posedge clk);  // Accepting edge
    #1;
    instValid = 1'b0;
    wbWrite   = 1'b0;
    waitOutValid();
    checkValue("exAluIn1", expV[0], exAluIn1);
    checkValue("exAluIn2", expV[1], exAluIn2);
    checkValue("exAluOp", expV[2], exAluOp);
    checkValue("exZEn", expV[3], exZEn);
    checkValue("exNvEn", expV[4], exNvEn);
    checkValue("memWriteData", expV[5], memWriteData);
    checkValue("memEnable", expV[6], memEnable);
    checkValue("memWrite", expV[7], memWrite);
    checkValue("wbDst", expV[8], wbDst);
    checkValue("wbRegWrite", expV[9], wbRegWrite);
    checkValue("wbMemToReg", expV[10], wbMemToReg);
    checkValue("wbHalt", expV[11], wbHalt);
    checkValue("wbPcs", expV[12], wbPcs);
    checkValue("branchTarget", expV[13], branchTarget);
    checkValue("branchTaken", expV[14], branchTaken);
    @(posedge clk);
    #1;
    checkValue("outValid", '0, outValid);  // High for one cycle only
  endtask

  // Let every credit come home, then stop the consumer from freeing slots
  task automatic drainReturns();
    int waited;
    waited = 0;
    while (outstanding != 0 && waited < TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (outstanding != 0)
      stopWithError("consumer model did not return its credits in time");
    @(posedge clk);  // Last pulse reaches the counter
    #1;
    holdReturns = 1'b1;
  endtask

  task automatic stallThenIssue();
    checkValue("outstanding", 16'(`DEC_CREDITS), 16'(outstanding));
    checkValue("instReady", '0, instReady);  // Out of credits
    instValid = 1'b1;
    repeat (STALL_CYCLES) begin
      @(posedge clk);
      #1;
      checkValue("instReady", '0, instReady);
      checkValue("outValid", '0, outValid);
    end
    holdReturns = 1'b0;  // Consumer frees its buffers again
    issueAndCheck();
  endtask

  // After HLT nothing issues until reset
  task automatic checkHaltLock(input int cycles);
    instValid = 1'b1;
    repeat (cycles) begin
      @(posedge clk);
      #1;
      checkValue("instReady", '0, instReady);
      checkValue("outValid", '0, outValid);
    end
    instValid = 1'b0;
    applyReset();
  endtask

  task automatic readExpected(input int fd);
    int code;
    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                   expV[0], expV[1], expV[2], expV[3], expV[4], expV[5], expV[6],
                   expV[7], expV[8], expV[9], expV[10], expV[11], expV[12],
                   expV[13], expV[14]);
    if (code != 15)
      stopWithError($sformatf("expected values missing for case %0d", caseNum + 1));
  endtask

  //////////////////////////////
  // Consumer credit returns
  //////////////////////////////
  initial begin : consumer
    logic [1:0] delay;
    cycleCount = 0;
    forever begin
      @(posedge clk);
      cycleCount++;
      #1;
      if (!resetting) begin
        if (outValid) begin
          lfsrState = lfsrNext(lfsrState);  // One step per delay bit
          delay[0]  = lfsrState[0];
          lfsrState = lfsrNext(lfsrState);
          delay[1]  = lfsrState[0];
          dueQ.push_back(cycleCount + int'(delay));
          outstanding++;
        end
        if (!holdReturns && dueQ.size() != 0 && dueQ[0] <= cycleCount) begin
          void'(dueQ.pop_front());
          outstanding--;
          creditReturn = 1'b1;  // One slot per pulse
        end else begin
          creditReturn = 1'b0;
        end
      end
    end
  end

  //////////////////////////////
  // Case file driver
  //////////////////////////////
  initial begin
    int                 fd;
    int                 code;
    int                 haltCycles;
    logic [7:0]         tag;
    logic [8*128-1:0]   skipLine;
    logic [`DATA_W-1:0] regV, valV, instV, pcV, flagV;
    rstN         = 1'b0;
    instValid    = 1'b0;
    inst         = '0;
    pcNext       = '0;
    flags        = '0;
    wbRd         = '0;
    wbWrite      = 1'b0;
    wbData       = '0;
    creditReturn = 1'b0;
    holdReturns  = 1'b0;
    resetting    = 1'b1;
    lfsrState    = 32'hec22;
    caseNum      = 0;
    applyReset();
    fd = $fopen("verification/decodeCases.txt", "r");
    if (fd == 0) stopWithError("cannot open verification/decodeCases.txt");
    while ($fscanf(fd, " %c", tag) == 1) begin
      case (tag)
        "#": code = $fgets(skipLine, fd);  // Comment line
        "W": begin
          code = $fscanf(fd, "%h %h", regV, valV);
          if (code != 2) stopWithError("malformed register write line");
          driveWrite(regV[`REG_AW-1:0], valV);
        end
        "I", "F", "P": begin
          regV = '0;
          valV = '0;
          if (tag == "F") begin
            code = $fscanf(fd, "%h %h", regV, valV);  // Write on the accepting edge
            if (code != 2) stopWithError("malformed forwarding line");
          end
          code = $fscanf(fd, "%h %h %h", instV, pcV, flagV);
          if (code != 3) stopWithError("malformed instruction line");
          readExpected(fd);
          caseNum++;
          inst   = instV;
          pcNext = pcV;
          flags  = flagV[2:0];
          if (tag == "F") begin
            wbRd    = regV[`REG_AW-1:0];
            wbData  = valV;
            wbWrite = 1'b1;
          end
          if (tag == "P") begin
            stallThenIssue();
          end else begin
            instValid = 1'b1;
            issueAndCheck();
          end
        end
        "H": drainReturns();
        "X": begin
          code = $fscanf(fd, "%d", haltCycles);
          if (code != 1) stopWithError("malformed halt check line");
          checkHaltLock(haltCycles);
        end
        default: stopWithError($sformatf("unknown line kind %c in case file", tag));
      endcase
    end
    $fclose(fd);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule
